//--- Bender.yml
package:
  name: tile_render

sources:
  - files:
      - common/ppu_render_pkg.sv
      - tile_render/plane_shifter.sv
      - tile_render/pixel_priority.sv
      - tile_render/vga_write_gen.sv
      - tile_render/tile_render.sv
  - target: test
    files:
      - test/tile_render_asserts.sv
      - test/tb_tile_render.sv

//--- common/ppu_render_pkg.sv
`default_nettype none

package ppu_render_pkg;

	// Screen coordinate width for row and column
	localparam int COORD_W = 9;

	// Width of one palette color
	localparam int COLOR_W = 8;

	// Pixels drawn per slice
	localparam int TILE_W = 8;

	// Mask register bits
	localparam int MASK_SPRITE_BIT = 4;
	localparam int MASK_BG_BIT = 3;

	// Sprite attribute bit that puts the sprite behind the background
	localparam int ATTR_BEHIND_BIT = 5;

	// Color for transparent or disabled pixels
	localparam logic [COLOR_W-1:0] BACKDROP_COLOR = '0;

	// One slice command from the driver
	typedef struct packed {
		logic [COORD_W-1:0] start_row;
		logic [COORD_W-1:0] start_col;
		logic [7:0]         mask;
	} tile_cmd_t;

	// Two pattern planes of one tile row
	// Bit 7 is the leftmost pixel
	typedef struct packed {
		logic [7:0] pat_hi;
		logic [7:0] pat_lo;
	} plane_t;

	// Sprite palette with attribute byte
	// Color 0 is transparent so it is not carried
	typedef struct packed {
		logic [7:0]         attr;
		logic [COLOR_W-1:0] color1;
		logic [COLOR_W-1:0] color2;
		logic [COLOR_W-1:0] color3;
	} sprite_pal_t;

	// Background palette, index 0 maps to the backdrop
	typedef struct packed {
		logic [COLOR_W-1:0] color1;
		logic [COLOR_W-1:0] color2;
		logic [COLOR_W-1:0] color3;
	} bg_pal_t;

	// One write into the VGA pixel memory
	typedef struct packed {
		logic [COORD_W-1:0] row;
		logic [COORD_W-1:0] col;
		logic [COLOR_W-1:0] data;
	} vga_wr_t;

endpackage

`default_nettype wire

//--- sim.f
common/ppu_render_pkg.sv
tile_render/plane_shifter.sv
tile_render/pixel_priority.sv
tile_render/vga_write_gen.sv
tile_render/tile_render.sv
test/tile_render_asserts.sv
test/tb_tile_render.sv

//--- test/tb_tile_render.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the tile slice renderer
// Seeded random slices, checked against a reference model of the priority rule
module tb_tile_render;

	localparam int NUM_SLICES = 300;
	localparam int CLK_NS = 100;
	localparam int RESET_CYCLES = 8;
	// 20 cycles per slice plus the reset time
	localparam int WATCHDOG_NS = NUM_SLICES * 20 * CLK_NS + RESET_CYCLES * CLK_NS;

	logic clk;
	logic rst;
	logic start;
	ppu_render_pkg::tile_cmd_t   cmd;
	ppu_render_pkg::plane_t      sprite_plane;
	ppu_render_pkg::sprite_pal_t sprite_pal;
	ppu_render_pkg::plane_t      bg_plane;
	ppu_render_pkg::bg_pal_t     bg_pal;
	logic                        busy;
	logic                        vga_write_en;
	ppu_render_pkg::vga_wr_t     vga_wr;

	integer seed;
	int errors = 0;
	int checks = 0;
	int accepted = 0;
	int wrap_slices = 0;
	// Current rising edge number and the edge of the last accept
	int cycle = 0;
	int e0 = -1000;
	logic model_busy = 1'b0;
	logic seen_write = 1'b0;
	// Expected writes in the order the DUT makes them
	ppu_render_pkg::vga_wr_t exp_q[$];

	tile_render u_dut (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.cmd          (cmd),
		.sprite_plane (sprite_plane),
		.sprite_pal   (sprite_pal),
		.bg_plane     (bg_plane),
		.bg_pal       (bg_pal),
		.busy         (busy),
		.vga_write_en (vga_write_en),
		.vga_wr       (vga_wr)
	);

	bind tile_render tile_render_asserts u_asserts (
		.clk          (clk),
		.rst          (rst),
		.busy         (busy),
		.vga_write_en (vga_write_en)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// Priority rule for one pixel
	function automatic logic [ppu_render_pkg::COLOR_W-1:0] expected_color(
		input logic [1:0]                  sidx,
		input logic [1:0]                  bidx,
		input logic [7:0]                  mask,
		input ppu_render_pkg::sprite_pal_t sp,
		input ppu_render_pkg::bg_pal_t     bp
	);
		logic [ppu_render_pkg::COLOR_W-1:0] spr_tab [0:3];
		logic [ppu_render_pkg::COLOR_W-1:0] bg_tab [0:3];
		logic                               show_sprite;
		spr_tab[0] = '0;
		spr_tab[1] = sp.color1;
		spr_tab[2] = sp.color2;
		spr_tab[3] = sp.color3;
		// Background index 0 is the backdrop
		bg_tab[0] = '0;
		bg_tab[1] = bp.color1;
		bg_tab[2] = bp.color2;
		bg_tab[3] = bp.color3;
		show_sprite = mask[ppu_render_pkg::MASK_SPRITE_BIT] && (sidx != 2'd0) &&
			(!sp.attr[ppu_render_pkg::ATTR_BEHIND_BIT] || (bidx == 2'd0));
		if (show_sprite) begin
			return spr_tab[sidx];
		end else if (mask[ppu_render_pkg::MASK_BG_BIT]) begin
			return bg_tab[bidx];
		end
		// Both layers off here
		return '0;
	endfunction

	// Model of one accepted slice
	// Pixel k takes plane bit 7-k
	task automatic queue_expected_writes(
		input ppu_render_pkg::tile_cmd_t   c,
		input ppu_render_pkg::plane_t      sp,
		input ppu_render_pkg::sprite_pal_t spal,
		input ppu_render_pkg::plane_t      bp,
		input ppu_render_pkg::bg_pal_t     bpal
	);
		ppu_render_pkg::vga_wr_t w;
		logic [1:0]              sidx;
		logic [1:0]              bidx;
		if (c.start_col > 9'd504) begin
			wrap_slices++;
		end
		for (int k = 0; k < ppu_render_pkg::TILE_W; k++) begin
			sidx = {sp.pat_hi[7-k], sp.pat_lo[7-k]};
			bidx = {bp.pat_hi[7-k], bp.pat_lo[7-k]};
			w.row = c.start_row;
			// Column wraps modulo 512
			w.col = 9'(c.start_col + k);
			w.data = expected_color(sidx, bidx, c.mask, spal, bpal);
			exp_q.push_back(w);
		end
	endtask

	task automatic drive_random_inputs();
		cmd = 26'($random(seed));
		// Push some slices toward the right edge so they wrap
		if (({$random(seed)} % 8) == 0) begin
			cmd.start_col = 9'd504 + 9'({$random(seed)} % 8);
		end
		sprite_plane = 16'($random(seed));
		sprite_pal = $random(seed);
		bg_plane = 16'($random(seed));
		bg_pal = 24'($random(seed));
	endtask

	// Monitor and model timing
	// Values seen here were set by the previous edge
	always @(posedge clk) begin : monitor
		logic                    exp_busy;
		logic                    exp_we;
		ppu_render_pkg::vga_wr_t exp_wr;
		cycle++;
		// busy is high after E0 to E0+9
		// Writes follow E0+2 to E0+9
		exp_busy = (cycle - 1 >= e0) && (cycle - 1 <= e0 + 9);
		exp_we = (cycle - 1 >= e0 + 2) && (cycle - 1 <= e0 + 9);
		checks++;
		assert (busy === exp_busy) else begin
			errors++;
			$display("[FAIL] %0t busy is %b, expected %b", $time, busy, exp_busy);
		end
		checks++;
		assert (vga_write_en === exp_we) else begin
			errors++;
			$display("[FAIL] %0t vga_write_en is %b, expected %b", $time, vga_write_en, exp_we);
		end
		if (vga_write_en === 1'b1) begin
			seen_write = 1'b1;
			checks++;
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("The DUT wrote a pixel that the model did not expect");
			end
			if (exp_q.size() != 0) begin
				exp_wr = exp_q.pop_front();
				checks++;
				assert (vga_wr === exp_wr) else begin
					errors++;
					$display("[FAIL] %0t write row %0d col %0d data %02h, expected %0d %0d %02h",
						$time, vga_wr.row, vga_wr.col, vga_wr.data,
						exp_wr.row, exp_wr.col, exp_wr.data);
				end
			end
		end else if (!seen_write) begin
			// Write bus stays cleared until the first slice
			checks++;
			assert (vga_wr === '0) else begin
				errors++;
				$display("[FAIL] %0t vga_wr is %h before any write", $time, vga_wr);
			end
		end
		// Start rule with the inputs as they are at this edge
		if (rst && start && !exp_busy) begin
			e0 = cycle;
			accepted++;
			queue_expected_writes(cmd, sprite_plane, sprite_pal, bg_plane, bg_pal);
		end
		model_busy = (cycle >= e0) && (cycle <= e0 + 9);
	end

	// Stimulus on the falling edge
	initial begin : driver
		int missing;
		seed = 59;
		rst = 1'b0;
		// Start held through reset must not begin a slice
		start = 1'b1;
		drive_random_inputs();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		while (accepted < NUM_SLICES) begin
			// Inputs change every cycle even while a slice runs
			drive_random_inputs();
			if (model_busy) begin
				start = 1'($random(seed));
			end else begin
				// Idle gaps of random length
				start = (({$random(seed)} % 3) != 0);
			end
			@(negedge clk);
		end
		start = 1'b0;
		repeat (ppu_render_pkg::TILE_W + 4) @(negedge clk);
		missing = exp_q.size();
		checks++;
		assert (missing == 0) else begin
			errors++;
			$display("%0d expected writes never appeared", missing);
		end
		errors += u_dut.u_asserts.assert_errors;
		$display("Checks %0d, errors %0d, slices %0d, wrapping slices %0d",
			checks, errors, accepted, wrap_slices);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: only %0d of %0d slices were accepted in the time limit",
			accepted, NUM_SLICES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tile_render_asserts.sv
`timescale 1ns/100ps
`default_nettype none

// Protocol checks on busy and the write strobe, bound into tile_render
module tile_render_asserts (
	input wire clk,
	input wire rst,
	input wire busy,
	input wire vga_write_en
);

	// Number of failed assertions so far
	int assert_errors = 0;

	// A write can only happen inside a slice
	a_write_in_busy: assert property (
		@(posedge clk) disable iff (!rst) vga_write_en |-> busy
	) else begin
		assert_errors++;
		$error("vga_write_en is high while busy is low");
	end

	// Each slice writes exactly 8 pixels in a row
	a_write_burst_len: assert property (
		@(posedge clk) disable iff (!rst)
		$rose(vga_write_en) |-> vga_write_en [*8] ##1 !vga_write_en
	) else begin
		assert_errors++;
		$error("vga_write_en burst is not exactly 8 cycles long");
	end

	// Reset clears busy at once
	a_busy_in_reset: assert property (
		@(posedge clk) !rst |-> !busy
	) else begin
		assert_errors++;
		$error("busy is high during reset");
	end

	// No slice is running on the first edge after reset
	a_busy_after_reset: assert property (
		@(posedge clk) $rose(rst) |-> !busy
	) else begin
		assert_errors++;
		$error("busy is high right after reset");
	end

endmodule

`default_nettype wire

//--- tile_render/pixel_priority.sv
`timescale 1ns/100ps
`default_nettype none

// Execute stage
// Picks sprite or background for one pixel and registers the color
module pixel_priority (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                pixel_valid,
	input  wire  [7:0]                         mask,
	input  wire  [1:0]                         sprite_index,
	input  ppu_render_pkg::sprite_pal_t        sprite_pal,
	input  wire  [1:0]                         bg_index,
	input  ppu_render_pkg::bg_pal_t            bg_pal,
	output logic [ppu_render_pkg::COLOR_W-1:0] color,
	output logic                               color_valid
);

	// Layer enables from the mask register
	logic sprite_en;
	logic bg_en;

	// Sprite sits behind the background
	logic behind;

	logic sprite_opaque;
	logic bg_opaque;
	logic sprite_wins;

	// Palette lookups for each layer
	logic [ppu_render_pkg::COLOR_W-1:0] sprite_color;
	logic [ppu_render_pkg::COLOR_W-1:0] bg_color;

	// Resolved color before the register
	logic [ppu_render_pkg::COLOR_W-1:0] color_d;

	assign sprite_en = mask[ppu_render_pkg::MASK_SPRITE_BIT];
	assign bg_en     = mask[ppu_render_pkg::MASK_BG_BIT];
	assign behind    = sprite_pal.attr[ppu_render_pkg::ATTR_BEHIND_BIT];

	assign sprite_opaque = (sprite_index != 2'd0);
	assign bg_opaque     = (bg_index != 2'd0);

	// Behind sprites still show through a transparent background
	assign sprite_wins = sprite_en && sprite_opaque && (!behind || !bg_opaque);

	always_comb begin
		case (sprite_index)
			2'd1:    sprite_color = sprite_pal.color1;
			2'd2:    sprite_color = sprite_pal.color2;
			2'd3:    sprite_color = sprite_pal.color3;
			default: sprite_color = ppu_render_pkg::BACKDROP_COLOR;
		endcase
	end

	always_comb begin
		case (bg_index)
			2'd1:    bg_color = bg_pal.color1;
			2'd2:    bg_color = bg_pal.color2;
			2'd3:    bg_color = bg_pal.color3;
			default: bg_color = ppu_render_pkg::BACKDROP_COLOR;
		endcase
	end

	always_comb begin
		if (sprite_wins) begin
			color_d = sprite_color;
		end else if (bg_en) begin
			color_d = bg_color;
		end else begin
			// Nothing drawn here, no old value held
			color_d = ppu_render_pkg::BACKDROP_COLOR;
		end
	end

	// One cycle of latency
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			color       <= '0;
			color_valid <= 1'b0;
		end else begin
			color_valid <= pixel_valid;
			// Color only moves with a valid pixel
			if (pixel_valid) begin
				color <= color_d;
			end
		end
	end

endmodule

`default_nettype wire

//--- tile_render/plane_shifter.sv
`timescale 1ns/100ps
`default_nettype none

// Decode stage
// Holds both pattern planes of one layer and presents the index of the
// current pixel, leftmost pixel first
module plane_shifter #(
	parameter type payload_t = ppu_render_pkg::bg_pal_t
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     load,
	input  wire                     shift,
	input  ppu_render_pkg::plane_t  plane,
	input  payload_t                payload_in,
	output logic [1:0]              index,
	output payload_t                payload
);

	// Working copy of the planes
	ppu_render_pkg::plane_t plane_q;

	// Palette data for the whole slice
	payload_t payload_q;

	// Planes shift toward the MSB, one pixel per step
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			plane_q <= '0;
		end else if (load) begin
			plane_q <= plane;
		end else if (shift) begin
			plane_q.pat_hi <= {plane_q.pat_hi[6:0], 1'b0};
			plane_q.pat_lo <= {plane_q.pat_lo[6:0], 1'b0};
		end
	end

	// Payload only changes on load
	always_ff @(posedge clk) begin
		if (load) begin
			payload_q <= payload_in;
		end
	end

	// Top bit pair is the current pixel
	// High plane gives the upper index bit
	assign index = {plane_q.pat_hi[7], plane_q.pat_lo[7]};

	assign payload = payload_q;

endmodule

`default_nettype wire

//--- tile_render/tile_render.sv
`timescale 1ns/100ps
`default_nettype none

// Draws one 8 pixel tile slice into the VGA pixel memory
// Decode, execute and result stages run as a short pipeline
module tile_render (
	input  wire                             clk,
	input  wire                             rst,
	input  wire                             start,
	input  ppu_render_pkg::tile_cmd_t       cmd,
	input  ppu_render_pkg::plane_t          sprite_plane,
	input  ppu_render_pkg::sprite_pal_t     sprite_pal,
	input  ppu_render_pkg::plane_t          bg_plane,
	input  ppu_render_pkg::bg_pal_t         bg_pal,
	output logic                            busy,
	output logic                            vga_write_en,
	output ppu_render_pkg::vga_wr_t         vga_wr
);

	// Start taken while idle
	logic accept;

	// Slice counter
	// 1 to 8 are pixel cycles, 9 and 10 drain the pipeline
	logic [3:0] slice_cnt;
	logic       pixel_valid;

	// Mask register as seen at accept
	logic [7:0] mask_q;

	// Decode stage outputs
	logic [1:0]                  sprite_index;
	logic [1:0]                  bg_index;
	ppu_render_pkg::sprite_pal_t sprite_pal_q;
	ppu_render_pkg::bg_pal_t     bg_pal_q;

	// Execute stage outputs
	logic [ppu_render_pkg::COLOR_W-1:0] color;
	logic                               color_valid;

	assign busy   = (slice_cnt != 4'd0);
	assign accept = start && !busy;

	// Counter steps through the slice and drops back to idle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			slice_cnt <= 4'd0;
		end else if (accept) begin
			slice_cnt <= 4'd1;
		end else if (slice_cnt == 4'(ppu_render_pkg::TILE_W + 2)) begin
			slice_cnt <= 4'd0;
		end else if (busy) begin
			slice_cnt <= slice_cnt + 4'd1;
		end
	end

	// First TILE_W busy cycles carry pixels
	assign pixel_valid = busy && (slice_cnt <= 4'(ppu_render_pkg::TILE_W));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mask_q <= 8'd0;
		end else if (accept) begin
			mask_q <= cmd.mask;
		end
	end

	// Sprite layer decode
	plane_shifter #(
		.payload_t (ppu_render_pkg::sprite_pal_t)
	) u_sprite_dec (
		.clk        (clk),
		.rst        (rst),
		.load       (accept),
		.shift      (pixel_valid),
		.plane      (sprite_plane),
		.payload_in (sprite_pal),
		.index      (sprite_index),
		.payload    (sprite_pal_q)
	);

	// Background layer decode
	plane_shifter #(
		.payload_t (ppu_render_pkg::bg_pal_t)
	) u_bg_dec (
		.clk        (clk),
		.rst        (rst),
		.load       (accept),
		.shift      (pixel_valid),
		.plane      (bg_plane),
		.payload_in (bg_pal),
		.index      (bg_index),
		.payload    (bg_pal_q)
	);

	pixel_priority u_prio (
		.clk          (clk),
		.rst          (rst),
		.pixel_valid  (pixel_valid),
		.mask         (mask_q),
		.sprite_index (sprite_index),
		.sprite_pal   (sprite_pal_q),
		.bg_index     (bg_index),
		.bg_pal       (bg_pal_q),
		.color        (color),
		.color_valid  (color_valid)
	);

	// Start address is latched by the result stage on the accept edge
	vga_write_gen u_wr (
		.clk          (clk),
		.rst          (rst),
		.load         (accept),
		.start_row    (cmd.start_row),
		.start_col    (cmd.start_col),
		.color        (color),
		.color_valid  (color_valid),
		.vga_write_en (vga_write_en),
		.vga_wr       (vga_wr)
	);

endmodule

`default_nettype wire

//--- tile_render/vga_write_gen.sv
`timescale 1ns/100ps
`default_nettype none

// Result stage
// Turns each resolved color into a pixel memory write along one row
module vga_write_gen (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                load,
	input  wire  [ppu_render_pkg::COORD_W-1:0] start_row,
	input  wire  [ppu_render_pkg::COORD_W-1:0] start_col,
	input  wire  [ppu_render_pkg::COLOR_W-1:0] color,
	input  wire                                color_valid,
	output logic                               vga_write_en,
	output ppu_render_pkg::vga_wr_t            vga_wr
);

	// Row stays fixed for the slice
	logic [ppu_render_pkg::COORD_W-1:0] row_q;

	// Column of the next write
	logic [ppu_render_pkg::COORD_W-1:0] col_ptr;

	// Address latch and column stepping
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_q   <= '0;
			col_ptr <= '0;
		end else if (load) begin
			row_q   <= start_row;
			col_ptr <= start_col;
		end else if (color_valid) begin
			// Wraps at 512, off screen columns are not checked
			col_ptr <= col_ptr + 1'b1;
		end
	end

	// Registered write toward the pixel memory
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vga_write_en <= 1'b0;
			vga_wr       <= '0;
		end else begin
			vga_write_en <= color_valid;
			if (color_valid) begin
				vga_wr.row  <= row_q;
				vga_wr.col  <= col_ptr;
				vga_wr.data <= color;
			end
		end
	end

endmodule

`default_nettype wire
